//--- rtl/trap_unit_config.svh
`ifndef TRAP_UNIT_CONFIG_SVH
`define TRAP_UNIT_CONFIG_SVH

// Data path width
`define XLEN 32

// Input queue entries, also the requester's starting credits
`define REQ_DEPTH 4

// Output buffer entries
`define RESP_DEPTH 4

// Value read back from mhartid
`define HART_ID_VALUE 0

`endif

//--- rtl/csr_arch_pkg.sv
`include "trap_unit_config.svh"

package csr_arch_pkg;

    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [11:0]      csr_addr_t;
    typedef logic [3:0]       cause_t;

    typedef enum logic [1:0] {
        USER       = 2'b00,
        SUPERVISOR = 2'b01,
        MACHINE    = 2'b11
    } priv_t;

    localparam csr_addr_t SSTATUS  = 12'h100;
    localparam csr_addr_t STVEC    = 12'h105;
    localparam csr_addr_t SSCRATCH = 12'h140;
    localparam csr_addr_t SEPC     = 12'h141;
    localparam csr_addr_t SCAUSE   = 12'h142;
    localparam csr_addr_t STVAL    = 12'h143;
    localparam csr_addr_t MSTATUS  = 12'h300;
    localparam csr_addr_t MTVEC    = 12'h305;
    localparam csr_addr_t MSCRATCH = 12'h340;
    localparam csr_addr_t MEPC     = 12'h341;
    localparam csr_addr_t MCAUSE   = 12'h342;
    localparam csr_addr_t MTVAL    = 12'h343;
    localparam csr_addr_t MHARTID  = 12'hF14;

    localparam int MSTATUS_SIE  = 1;
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_SPIE = 5;
    localparam int MSTATUS_MPIE = 7;
    localparam int MSTATUS_SPP  = 8;
    localparam int MSTATUS_MPP  = 11; // Low bit of the two bit field

    // Fields visible through sstatus, and all implemented mstatus fields
    localparam xlen_t SSTATUS_MASK = xlen_t'((1 << MSTATUS_SIE) | (1 << MSTATUS_SPIE)
                                             | (1 << MSTATUS_SPP));
    localparam xlen_t MSTATUS_MASK = SSTATUS_MASK
                                     | xlen_t'((1 << MSTATUS_MIE) | (1 << MSTATUS_MPIE)
                                               | (3 << MSTATUS_MPP));

endpackage

//--- rtl/trap_req_pkg.sv
package trap_req_pkg;
    import csr_arch_pkg::*;

    typedef enum logic [2:0] {
        CSRRW     = 3'b001,
        CSRRS     = 3'b010,
        CSRRC     = 3'b011,
        SRET      = 3'b100,
        EXCEPTION = 3'b101,
        INTERRUPT = 3'b110,
        MRET      = 3'b111
    } trap_op_t;

    typedef struct packed {
        trap_op_t  op;
        csr_addr_t addr;
        xlen_t     wdata;   // Write value, faulting pc for traps
        xlen_t     tval;
        cause_t    cause;
        logic      to_s;    // Take the trap in supervisor mode
    } csr_req_t;

    typedef struct packed {
        xlen_t rdata;       // Old CSR value or redirect pc
        logic  excp;
        priv_t priv;        // Privilege after the request
    } csr_resp_t;

endpackage

//--- rtl/csr_req_queue.sv
`include "trap_unit_config.svh"

module csr_req_queue
    import trap_req_pkg::*;
(
    input  wire logic cpu_clock_i,
    input  wire logic rst_n_i,
    input  wire logic req_valid_i,
    input  csr_req_t  req_i,
    input  wire logic pop_i,
    output logic      head_valid_o,
    output csr_req_t  head_o,
    output logic      req_credit_o
);
    localparam int DEPTH = `REQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    csr_req_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign head_valid_o = (count != '0);
    assign head_o       = mem[rd_ptr];

    always_ff @(posedge cpu_clock_i) begin
        if (req_valid_i) begin
            mem[wr_ptr] <= req_i;
        end
    end

    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            req_credit_o <= 1'b0;
        end else begin
            if (req_valid_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count        <= count + CNT_W'(req_valid_i) - CNT_W'(pop_i);
            req_credit_o <= pop_i; // One credit back per entry consumed
        end
    end

    // Requester may only push while holding a credit
    a_no_push_when_full: assert property (
        @(posedge cpu_clock_i) disable iff (!rst_n_i)
        req_valid_i |-> (count != CNT_W'(DEPTH))
    ) else $error("request pushed into a full queue");

endmodule

//--- rtl/csr_file.sv
`include "trap_unit_config.svh"

module csr_file
    import csr_arch_pkg::*, trap_req_pkg::*;
(
    input  wire logic cpu_clock_i,
    input  wire logic rst_n_i,
    input  wire logic head_valid_i,
    input  csr_req_t  head_i,
    input  wire logic space_i,
    output logic      pop_o,
    output logic      push_o,
    output csr_resp_t resp_o
);
    priv_t priv_q;
    priv_t priv_nxt;
    xlen_t mstatus_q;
    xlen_t mstatus_wr;
    xlen_t mtvec_q;
    xlen_t stvec_q;
    xlen_t mscratch_q;
    xlen_t sscratch_q;
    xlen_t mepc_q;
    xlen_t sepc_q;
    xlen_t mcause_q;
    xlen_t scause_q;
    xlen_t mtval_q;
    xlen_t stval_q;

    xlen_t csr_old;
    xlen_t csr_new;
    logic  csr_exists;
    logic  is_csr;
    logic  csr_we;
    logic  csr_ok;
    logic  is_trap;
    logic  is_intr;
    logic  mret_ok;
    logic  sret_ok;
    xlen_t trap_pc;
    xlen_t trap_cause;
    xlen_t tvec_sel;
    xlen_t trap_target;

    // Only direct and vectored modes are kept
    function automatic xlen_t legal_tvec(xlen_t value);
        return {value[`XLEN-1:2], 1'b0, value[1:0] == 2'b01};
    endfunction

    function automatic xlen_t align_pc(xlen_t pc);
        return {pc[`XLEN-1:2], 2'b00};
    endfunction

    assign pop_o  = head_valid_i && space_i;
    assign push_o = pop_o; // Every consumed request yields one response

    assign is_csr  = (head_i.op == CSRRW) || (head_i.op == CSRRS) || (head_i.op == CSRRC);
    assign is_intr = (head_i.op == INTERRUPT);
    assign is_trap = (head_i.op == EXCEPTION) || is_intr;
    assign mret_ok = (head_i.op == MRET) && (priv_q == MACHINE);
    assign sret_ok = (head_i.op == SRET) && (priv_q != USER);

    always_comb begin
        csr_exists = 1'b1;
        case (head_i.addr)
            MSTATUS:  csr_old = mstatus_q;
            SSTATUS:  csr_old = mstatus_q & SSTATUS_MASK;
            MTVEC:    csr_old = mtvec_q;
            STVEC:    csr_old = stvec_q;
            MSCRATCH: csr_old = mscratch_q;
            SSCRATCH: csr_old = sscratch_q;
            MEPC:     csr_old = mepc_q;
            SEPC:     csr_old = sepc_q;
            MCAUSE:   csr_old = mcause_q;
            SCAUSE:   csr_old = scause_q;
            MTVAL:    csr_old = mtval_q;
            STVAL:    csr_old = stval_q;
            MHARTID:  csr_old = xlen_t'(`HART_ID_VALUE);
            default: begin
                csr_old    = '0;
                csr_exists = 1'b0;
            end
        endcase
    end

    // Set or clear with a zero mask counts as a plain read
    assign csr_we = (head_i.op == CSRRW) || (head_i.wdata != '0);
    assign csr_ok = is_csr && csr_exists && (priv_q >= head_i.addr[9:8])
                    && !(csr_we && (&head_i.addr[11:10]));

    always_comb begin
        case (head_i.op)
            CSRRS:   csr_new = csr_old | head_i.wdata;
            CSRRC:   csr_new = csr_old & ~head_i.wdata;
            default: csr_new = head_i.wdata;
        endcase
    end

    always_comb begin
        mstatus_wr = csr_new & MSTATUS_MASK;
        if (csr_new[MSTATUS_MPP +: 2] == 2'b10) begin
            mstatus_wr[MSTATUS_MPP +: 2] = mstatus_q[MSTATUS_MPP +: 2]; // Reserved MPP ignored
        end
    end

    assign trap_pc    = align_pc(head_i.wdata);
    assign trap_cause = {is_intr, {(`XLEN - 1 - $bits(cause_t)){1'b0}}, head_i.cause};
    assign tvec_sel   = head_i.to_s ? stvec_q : mtvec_q;
    // Bit 0 of a legal tvec marks vectored mode
    assign trap_target = {tvec_sel[`XLEN-1:2], 2'b00}
                         + ((tvec_sel[0] && is_intr) ? xlen_t'({head_i.cause, 2'b00}) : '0);

    always_comb begin
        priv_nxt = priv_q;
        if (mret_ok) begin
            priv_nxt = priv_t'(mstatus_q[MSTATUS_MPP +: 2]);
        end else if (sret_ok) begin
            priv_nxt = mstatus_q[MSTATUS_SPP] ? SUPERVISOR : USER;
        end else if (is_trap) begin
            priv_nxt = head_i.to_s ? SUPERVISOR : MACHINE;
        end
    end

    always_comb begin
        resp_o.priv  = priv_nxt;
        resp_o.rdata = '0;
        resp_o.excp  = 1'b0;
        if (is_csr) begin
            resp_o.rdata = csr_ok ? csr_old : '0;
            resp_o.excp  = !csr_ok;
        end else if (is_trap) begin
            resp_o.rdata = trap_target;
        end else if (mret_ok) begin
            resp_o.rdata = mepc_q;
        end else if (sret_ok) begin
            resp_o.rdata = sepc_q;
        end else begin
            resp_o.excp = 1'b1; // xRET from the wrong mode
        end
    end

    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            priv_q     <= MACHINE;
            mstatus_q  <= '0;
            mtvec_q    <= '0;
            stvec_q    <= '0;
            mscratch_q <= '0;
            sscratch_q <= '0;
            mepc_q     <= '0;
            sepc_q     <= '0;
            mcause_q   <= '0;
            scause_q   <= '0;
            mtval_q    <= '0;
            stval_q    <= '0;
        end else if (pop_o) begin
            priv_q <= priv_nxt;
            if (mret_ok) begin
                mstatus_q[MSTATUS_MIE]       <= mstatus_q[MSTATUS_MPIE];
                mstatus_q[MSTATUS_MPIE]      <= 1'b1;
                mstatus_q[MSTATUS_MPP +: 2]  <= USER;
            end else if (sret_ok) begin
                mstatus_q[MSTATUS_SIE]  <= mstatus_q[MSTATUS_SPIE];
                mstatus_q[MSTATUS_SPIE] <= 1'b1;
                mstatus_q[MSTATUS_SPP]  <= 1'b0;
            end else if (is_trap && head_i.to_s) begin
                mstatus_q[MSTATUS_SPIE] <= is_intr | mstatus_q[MSTATUS_SIE];
                mstatus_q[MSTATUS_SIE]  <= 1'b0;
                mstatus_q[MSTATUS_SPP]  <= priv_q[0];
                sepc_q   <= trap_pc;
                scause_q <= trap_cause;
                stval_q  <= is_intr ? '0 : head_i.tval;
            end else if (is_trap) begin
                mstatus_q[MSTATUS_MPIE]     <= is_intr | mstatus_q[MSTATUS_MIE];
                mstatus_q[MSTATUS_MIE]      <= 1'b0;
                mstatus_q[MSTATUS_MPP +: 2] <= priv_q;
                mepc_q   <= trap_pc;
                mcause_q <= trap_cause;
                mtval_q  <= is_intr ? '0 : head_i.tval;
            end else if (csr_ok && csr_we) begin
                case (head_i.addr)
                    MSTATUS:  mstatus_q  <= mstatus_wr;
                    SSTATUS:  mstatus_q  <= (mstatus_q & ~SSTATUS_MASK) | (csr_new & SSTATUS_MASK);
                    MTVEC:    mtvec_q    <= legal_tvec(csr_new);
                    STVEC:    stvec_q    <= legal_tvec(csr_new);
                    MSCRATCH: mscratch_q <= csr_new;
                    SSCRATCH: sscratch_q <= csr_new;
                    MEPC:     mepc_q     <= align_pc(csr_new);
                    SEPC:     sepc_q     <= align_pc(csr_new);
                    MCAUSE:   mcause_q   <= csr_new;
                    SCAUSE:   scause_q   <= csr_new;
                    MTVAL:    mtval_q    <= csr_new;
                    STVAL:    stval_q    <= csr_new;
                    default: ;
                endcase
            end
        end
    end

    // MPP legalisation keeps MRET away from the reserved level
    a_priv_legal: assert property (
        @(posedge cpu_clock_i) disable iff (!rst_n_i)
        priv_q != 2'b10
    ) else $error("privilege holds the reserved encoding");

endmodule

//--- rtl/csr_resp_buffer.sv
`include "trap_unit_config.svh"

module csr_resp_buffer
    import trap_req_pkg::*;
(
    input  wire logic cpu_clock_i,
    input  wire logic rst_n_i,
    input  wire logic push_i,
    input  csr_resp_t resp_i,
    output logic      space_o,
    input  wire logic resp_credit_i,
    output logic      resp_valid_o,
    output csr_resp_t resp_o
);
    localparam int DEPTH = `RESP_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = 8; // Consumer credits held

    csr_resp_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] credit_cnt;
    logic [CRD_W-1:0] port_credits; // Credits in minus responses out, seen at the ports
    logic             send;

    assign space_o = (count != CNT_W'(DEPTH));
    assign send    = (count != '0) && (credit_cnt != '0);

    always_ff @(posedge cpu_clock_i) begin
        if (push_i) begin
            mem[wr_ptr] <= resp_i;
        end
        if (send) begin
            resp_o <= mem[rd_ptr];
        end
    end

    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            credit_cnt   <= '0;
            resp_valid_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count        <= count + CNT_W'(push_i) - CNT_W'(send);
            credit_cnt   <= credit_cnt + CRD_W'(resp_credit_i) - CRD_W'(send);
            resp_valid_o <= send; // Each response spends one credit
        end
    end

    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            port_credits <= '0;
        end else begin
            port_credits <= port_credits + CRD_W'(resp_credit_i) - CRD_W'(resp_valid_o);
        end
    end

    a_send_with_credit: assert property (
        @(posedge cpu_clock_i) disable iff (!rst_n_i)
        resp_valid_o |-> (port_credits != '0)
    ) else $error("response sent without a consumer credit");

endmodule

//--- rtl/trap_unit.sv
module trap_unit
    import trap_req_pkg::*;
(
    input  wire logic cpu_clock_i,
    input  wire logic rst_n_i,
    input  wire logic req_valid_i,
    input  csr_req_t  req_i,
    output logic      req_credit_o,
    input  wire logic resp_credit_i,
    output logic      resp_valid_o,
    output csr_resp_t resp_o
);
    logic      head_valid;
    csr_req_t  head;
    logic      pop;
    logic      push;
    logic      space;
    csr_resp_t file_resp;

    csr_req_queue req_queue0 (
        .cpu_clock_i  (cpu_clock_i),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_o       (head),
        .req_credit_o (req_credit_o)
    );

    csr_file file0 (
        .cpu_clock_i  (cpu_clock_i),
        .rst_n_i      (rst_n_i),
        .head_valid_i (head_valid),
        .head_i       (head),
        .space_i      (space),
        .pop_o        (pop),
        .push_o       (push),
        .resp_o       (file_resp)
    );

    csr_resp_buffer resp_buf0 (
        .cpu_clock_i   (cpu_clock_i),
        .rst_n_i       (rst_n_i),
        .push_i        (push),
        .resp_i        (file_resp),
        .space_o       (space),
        .resp_credit_i (resp_credit_i),
        .resp_valid_o  (resp_valid_o),
        .resp_o        (resp_o)
    );

endmodule

//--- testbench/tb_trap_unit.sv
`include "trap_unit_config.svh"

module tb_trap_unit
    import csr_arch_pkg::*, trap_req_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int    NUM_REQ        = 1500;
    localparam int    TIMEOUT_CYCLES = NUM_REQ * 12;
    localparam int    CONS_SLOTS     = 3;
    localparam xlen_t M_FIELDS       = 32'h0000_19AA; // MIE SIE MPIE SPIE SPP MPP
    localparam xlen_t S_FIELDS       = 32'h0000_0122;
    localparam csr_addr_t KEPT_ADDRS [13] = '{SSTATUS, STVEC, SSCRATCH, SEPC, SCAUSE, STVAL,
                                              MSTATUS, MTVEC, MSCRATCH, MEPC, MCAUSE, MTVAL,
                                              MHARTID};
    localparam csr_addr_t UNKNOWN_ADDRS [4] = '{12'h180, 12'h304, 12'hB00, 12'hC00};

    logic      cpu_clock_i;
    logic      rst_n_i;
    logic      req_valid_i;
    csr_req_t  req_i;
    logic      req_credit_o;
    logic      resp_credit_i;
    logic      resp_valid_o;
    csr_resp_t resp_o;

    csr_resp_t   exp_q [$];
    int          credits;
    int          sent;
    int          received;
    int          cons_outstanding;
    int          hold_cycles;
    int          cycle_count;

    priv_t m_priv;
    xlen_t m_csr [csr_addr_t]; // sstatus and mhartid are derived on read

    trap_unit dut0 (
        .cpu_clock_i   (cpu_clock_i),
        .rst_n_i       (rst_n_i),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .req_credit_o  (req_credit_o),
        .resp_credit_i (resp_credit_i),
        .resp_valid_o  (resp_valid_o),
        .resp_o        (resp_o)
    );

    initial begin
        cpu_clock_i = 1'b0;
        forever #10 cpu_clock_i = ~cpu_clock_i;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_data(input xlen_t got, input xlen_t exp, input int idx);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0d ns: response %0d rdata got %h, expected %h",
                                $time, idx, got, exp));
        end
    endtask

    task automatic check_excp(input logic got, input logic exp, input int idx);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0d ns: response %0d excp got %b, expected %b",
                                $time, idx, got, exp));
        end
    endtask

    task automatic check_priv(input priv_t got, input priv_t exp, input int idx);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0d ns: response %0d priv got %0d, expected %0d",
                                $time, idx, got, exp));
        end
    endtask

    task automatic reset_model();
        m_priv = MACHINE;
        for (int i = 0; i < 13; i++) begin
            if (KEPT_ADDRS[i] != SSTATUS && KEPT_ADDRS[i] != MHARTID) begin
                m_csr[KEPT_ADDRS[i]] = '0;
            end
        end
    endtask

    function automatic xlen_t model_read(csr_addr_t a);
        if (a == SSTATUS) return m_csr[MSTATUS] & S_FIELDS;
        if (a == MHARTID) return xlen_t'(`HART_ID_VALUE);
        return m_csr.exists(a) ? m_csr[a] : '0;
    endfunction

    task automatic model_write(input csr_addr_t a, input xlen_t v);
        xlen_t st;
        st = m_csr[MSTATUS];
        case (a)
            MSTATUS: begin
                if (v[MSTATUS_MPP +: 2] == 2'b10) begin
                    v[MSTATUS_MPP +: 2] = st[MSTATUS_MPP +: 2]; // Reserved level, keep old
                end
                m_csr[a] = v & M_FIELDS;
            end
            SSTATUS:      m_csr[MSTATUS] = (st & ~S_FIELDS) | (v & S_FIELDS);
            MTVEC, STVEC: m_csr[a] = (v & ~xlen_t'(3)) | ((v[1:0] == 2'b01) ? 32'h1 : 32'h0);
            MEPC, SEPC:   m_csr[a] = v & ~xlen_t'(3);
            default:      m_csr[a] = v;
        endcase
    endtask

    task automatic model_trap(input csr_req_t r, output xlen_t target);
        logic  intr;
        xlen_t st;
        xlen_t base;
        xlen_t cause;
        intr  = (r.op == INTERRUPT);
        st    = m_csr[MSTATUS];
        cause = (xlen_t'(intr) << 31) | xlen_t'(r.cause);
        if (r.to_s) begin
            st[MSTATUS_SPIE] = intr || st[MSTATUS_SIE];
            st[MSTATUS_SIE]  = 1'b0;
            st[MSTATUS_SPP]  = (m_priv != USER);
            m_csr[SEPC]      = r.wdata & ~xlen_t'(3);
            m_csr[SCAUSE]    = cause;
            m_csr[STVAL]     = intr ? '0 : r.tval;
            base             = m_csr[STVEC];
            m_priv           = SUPERVISOR;
        end else begin
            st[MSTATUS_MPIE]     = intr || st[MSTATUS_MIE];
            st[MSTATUS_MIE]      = 1'b0;
            st[MSTATUS_MPP +: 2] = m_priv;
            m_csr[MEPC]          = r.wdata & ~xlen_t'(3);
            m_csr[MCAUSE]        = cause;
            m_csr[MTVAL]         = intr ? '0 : r.tval;
            base                 = m_csr[MTVEC];
            m_priv               = MACHINE;
        end
        m_csr[MSTATUS] = st;
        target = (base & ~xlen_t'(3)) + ((base[0] && intr) ? xlen_t'(r.cause) * 4 : '0);
    endtask

    task automatic apply_model(input csr_req_t r, output csr_resp_t e);
        logic  known;
        logic  writes;
        xlen_t old_v;
        xlen_t new_v;
        xlen_t st;
        xlen_t target;
        e  = '0;
        st = m_csr[MSTATUS];
        case (r.op)
            CSRRW, CSRRS, CSRRC: begin
                known  = (r.addr == SSTATUS) || (r.addr == MHARTID) || m_csr.exists(r.addr);
                writes = (r.op == CSRRW) || (r.wdata != '0);
                if (known && m_priv >= r.addr[9:8] && !(writes && r.addr[11:10] == 2'b11)) begin
                    old_v = model_read(r.addr);
                    if (r.op == CSRRW) new_v = r.wdata;
                    else if (r.op == CSRRS) new_v = old_v | r.wdata;
                    else new_v = old_v & ~r.wdata;
                    if (writes) model_write(r.addr, new_v);
                    e.rdata = old_v;
                end else begin
                    e.excp = 1'b1;
                end
            end
            MRET: begin
                if (m_priv == MACHINE) begin
                    e.rdata              = m_csr[MEPC];
                    m_priv               = priv_t'(st[MSTATUS_MPP +: 2]);
                    st[MSTATUS_MIE]      = st[MSTATUS_MPIE];
                    st[MSTATUS_MPIE]     = 1'b1;
                    st[MSTATUS_MPP +: 2] = USER;
                    m_csr[MSTATUS]       = st;
                end else begin
                    e.excp = 1'b1;
                end
            end
            SRET: begin
                if (m_priv != USER) begin
                    e.rdata          = m_csr[SEPC];
                    m_priv           = st[MSTATUS_SPP] ? SUPERVISOR : USER;
                    st[MSTATUS_SIE]  = st[MSTATUS_SPIE];
                    st[MSTATUS_SPIE] = 1'b1;
                    st[MSTATUS_SPP]  = 1'b0;
                    m_csr[MSTATUS]   = st;
                end else begin
                    e.excp = 1'b1;
                end
            end
            default: begin
                model_trap(r, target);
                e.rdata = target;
            end
        endcase
        e.priv = m_priv;
    endtask

    function automatic csr_req_t random_request();
        csr_req_t    r;
        int unsigned pick;
        r       = '0;
        r.wdata = $urandom;
        r.tval  = $urandom;
        r.cause = cause_t'($urandom % 16);
        r.to_s  = 1'($urandom % 2);
        pick    = $urandom % 17;
        r.addr  = (pick < 13) ? KEPT_ADDRS[pick] : UNKNOWN_ADDRS[pick - 13];
        if ($urandom % 4 == 0) r.wdata = '0;
        else if ($urandom % 4 == 0) r.wdata = xlen_t'(1) << ($urandom % 32);
        // xRET and traps often enough to visit S and U mode
        case ($urandom % 16)
            0, 1, 2, 3: r.op = CSRRW;
            4, 5, 6:    r.op = CSRRS;
            7, 8, 9:    r.op = CSRRC;
            10, 11:     r.op = MRET;
            12, 13:     r.op = SRET;
            14:         r.op = EXCEPTION;
            default:    r.op = INTERRUPT;
        endcase
        return r;
    endfunction

    task automatic check_response();
        csr_resp_t e;
        if (exp_q.size() == 0 || cons_outstanding == 0) begin
            abort_run("a response arrived with no request or no consumer credit behind it");
        end else begin
            e = exp_q.pop_front();
            check_data(resp_o.rdata, e.rdata, received);
            check_excp(resp_o.excp, e.excp, received);
            check_priv(resp_o.priv, e.priv, received);
            received++;
            cons_outstanding--;
        end
    endtask

    task automatic sample_outputs();
        if (req_credit_o) credits++;
        if (credits > `REQ_DEPTH) abort_run("the DUT returned more request credits than it took");
        if (resp_valid_o) check_response();
    endtask

    task automatic drive_consumer();
        if (hold_cycles > 0) begin
            hold_cycles--;
            resp_credit_i <= 1'b0;
        end else if ($urandom % 48 == 0) begin
            hold_cycles = 20 + int'($urandom % 60); // Long stretch with no credits
            resp_credit_i <= 1'b0;
        end else if (cons_outstanding < CONS_SLOTS && $urandom % 2 == 0) begin
            cons_outstanding++;
            resp_credit_i <= 1'b1;
        end else begin
            resp_credit_i <= 1'b0;
        end
    endtask

    initial begin
        csr_req_t  r;
        csr_resp_t e;
        void'($urandom(48618));
        rst_n_i          = 1'b0;
        req_valid_i      = 1'b0;
        req_i            = '0;
        resp_credit_i    = 1'b0;
        credits          = `REQ_DEPTH;
        sent             = 0;
        received         = 0;
        cons_outstanding = 0;
        hold_cycles      = 0;
        reset_model();
        repeat (8) @(posedge cpu_clock_i);
        rst_n_i <= 1'b1;
        while (received < NUM_REQ) begin
            @(posedge cpu_clock_i);
            sample_outputs();
            if (sent < NUM_REQ && credits > 0 && $urandom % 4 != 0) begin
                r = random_request();
                apply_model(r, e);
                exp_q.push_back(e);
                req_i       <= r;
                req_valid_i <= 1'b1;
                credits--;
                sent++;
            end else begin
                req_valid_i <= 1'b0;
            end
            drive_consumer();
        end
        // Any extra response or late credit shows up here
        repeat (4) begin
            @(posedge cpu_clock_i);
            sample_outputs();
        end
        if (credits == `REQ_DEPTH && exp_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            abort_run($sformatf("run ended holding %0d request credits with %0d responses missing",
                                credits, exp_q.size()));
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge cpu_clock_i);
            cycle_count++;
        end
        abort_run($sformatf("timeout after %0d cycles with %0d of %0d responses received",
                            cycle_count, received, NUM_REQ));
    end

endmodule

//--- sources.f
+incdir+rtl
rtl/csr_arch_pkg.sv
rtl/trap_req_pkg.sv
rtl/csr_req_queue.sv
rtl/csr_file.sv
rtl/csr_resp_buffer.sv
rtl/trap_unit.sv
testbench/tb_trap_unit.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module tb_trap_unit -o sim_trap_unit
status=0
out=$(./obj_dir/sim_trap_unit 2>&1) || status=$?
printf '%s\n' "$out"
if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
